//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := scene_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+100
FAIL_MSG  := SOME TESTS FAILED

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@./$(SIM) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
design/scene_types_pkg.sv
design/scene_cmd_pkg.sv
design/scene_cmd_if.sv
design/cmd_intake.sv
design/camera_store.sv
design/light_store.sv
design/frame_sequencer.sv
design/scene_top.sv
test/clock_gen.sv
test/scene_asserts.sv
test/scene_tb.sv

//--- design/camera_store.sv
`default_nettype none
`timescale 1ns/1ps

module camera_store (
    input  wire                      clk_100mhz,
    input  wire                      rst,
    scene_cmd_if.store               bus,
    output scene_types_pkg::camera_t camera_output  // Display bank
);

    scene_types_pkg::camera_t bank [2];  // One record per bank
    scene_types_pkg::camera_t updated;   // Write bank record with the new field
    logic                     cam_set;

    assign cam_set = bus.valid && (bus.cmd.opcode == scene_cmd_pkg::OP_CAMERA_SET);

    // Field replace, the other six fields pass through
    always_comb begin
        updated = bank[bus.write_bank];
        case (scene_cmd_pkg::camera_prop_t'(bus.cmd.prop))
            scene_cmd_pkg::CP_X_LOC: updated.xloc = bus.cmd.data;
            scene_cmd_pkg::CP_Y_LOC: updated.yloc = bus.cmd.data;
            scene_cmd_pkg::CP_Z_LOC: updated.zloc = bus.cmd.data;
            scene_cmd_pkg::CP_X_FOR: updated.xfor = bus.cmd.data;
            scene_cmd_pkg::CP_Y_FOR: updated.yfor = bus.cmd.data;
            scene_cmd_pkg::CP_Z_FOR: updated.zfor = bus.cmd.data;
            scene_cmd_pkg::CP_FOV:   updated.fov  = bus.cmd.data;
            default: ;  // Unused code 7 leaves the record as is
        endcase
    end

    // Registers, so the update lands at the end of the pop cycle
    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            bank[0] <= '0;
            bank[1] <= '0;
        end else if (cam_set) begin
            bank[bus.write_bank] <= updated;
        end
    end

    assign camera_output = bank[~bus.write_bank];

    // Single cycle update, never anything pending
    assign bus.camera_idle = 1'b1;

endmodule

`default_nettype wire

//--- design/cmd_intake.sv
`default_nettype none
`timescale 1ns/1ps

module cmd_intake #(
    parameter int fifo_depth = scene_cmd_pkg::CMD_FIFO_DEPTH
) (
    input  wire                            clk_100mhz,
    input  wire                            rst,
    input  wire                            cmd_valid,    // Host spends one credit
    input  wire scene_cmd_pkg::scene_cmd_t cmd_word,
    output logic                           cmd_credit,   // One credit back per pop
    input  wire                            hold,         // From frame_sequencer
    scene_cmd_if.issue                     bus
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    scene_cmd_pkg::scene_cmd_t fifo_mem [fifo_depth];  // Command storage
    logic [ptr_w-1:0]          wr_ptr;
    logic [ptr_w-1:0]          rd_ptr;
    logic [cnt_w-1:0]          count;                  // Entries held
    logic                      not_empty;
    logic                      pop;

    // Circular increment, depth need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign not_empty = (count != '0);
    assign pop       = not_empty && !hold;

    // No full check, host credits bound the occupancy
    always_ff @(posedge clk_100mhz) begin
        if (cmd_valid) begin
            fifo_mem[wr_ptr] <= cmd_word;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + cnt_w'(cmd_valid) - cnt_w'(pop);  // Push and pop may coincide
        end
    end

    // Head shown before the pop so frame and render can be inspected
    assign bus.cmd    = not_empty ? fifo_mem[rd_ptr] : '0;  // Reads as nop when empty
    assign bus.valid  = pop;
    assign cmd_credit = pop;                                 // Same cycle as the pop

endmodule

`default_nettype wire

//--- design/frame_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module frame_sequencer (
    input  wire       clk_100mhz,
    input  wire       rst,
    scene_cmd_if.seq  bus,
    input  wire       controller_busy,  // Renderer still using the display bank
    output logic      hold,             // Keeps the head command in the FIFO
    output logic      output_enabled
);

    typedef enum logic [1:0] {
        ST_RUN,          // Commands flow
        ST_WAIT_FRAME,   // Frame at head, waiting on stores and controller
        ST_WAIT_RENDER   // Render at head, waiting on controller
    } seq_state_t;

    seq_state_t state;
    seq_state_t state_next;
    logic       head_frame;
    logic       head_render;
    logic       frame_ready;
    logic       render_ready;

    assign head_frame   = (bus.cmd.opcode == scene_cmd_pkg::OP_FRAME);
    assign head_render  = (bus.cmd.opcode == scene_cmd_pkg::OP_RENDER);
    assign frame_ready  = bus.camera_idle && bus.light_idle && !controller_busy;
    assign render_ready = !controller_busy;

    // Hold never depends on valid, the pop follows from hold
    always_comb begin
        state_next = state;
        hold       = 1'b0;
        case (state)
            ST_RUN: begin
                if (head_frame && !frame_ready) begin
                    hold       = 1'b1;
                    state_next = ST_WAIT_FRAME;
                end else if (head_render && !render_ready) begin
                    hold       = 1'b1;
                    state_next = ST_WAIT_RENDER;
                end
            end
            ST_WAIT_FRAME: begin
                hold = !frame_ready;             // Pops in the first ready cycle
                if (frame_ready) begin
                    state_next = ST_RUN;
                end
            end
            ST_WAIT_RENDER: begin
                hold = !render_ready;
                if (render_ready) begin
                    state_next = ST_RUN;
                end
            end
            default: state_next = ST_RUN;
        endcase
    end

    // Swap and enable take effect the cycle after the pop
    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            state          <= ST_RUN;
            bus.write_bank <= 1'b0;
            output_enabled <= 1'b0;
        end else begin
            state <= state_next;
            if (bus.valid && head_frame) begin
                bus.write_bank <= ~bus.write_bank;
                output_enabled <= 1'b1;
            end else if (bus.valid && head_render) begin
                output_enabled <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/light_store.sv
`default_nettype none
`timescale 1ns/1ps

module light_store #(
    parameter int num_lights = scene_types_pkg::NUM_LIGHTS
) (
    input  wire                               clk_100mhz,
    scene_cmd_if.store                        bus,
    input  wire scene_types_pkg::light_addr_t light_read_addr,
    output scene_types_pkg::light_t           light_output     // One cycle after the address
);

    logic                         light_set;
    logic                         rd_valid;   // Read stage, RAM addressed
    scene_cmd_pkg::scene_cmd_t    rd_cmd;
    logic                         mg_valid;   // Merge stage, RAM word back, written at its end
    scene_cmd_pkg::scene_cmd_t    mg_cmd;
    logic                         wr_valid;   // Write stage, copy of the record just written
    scene_types_pkg::light_addr_t wr_index;
    scene_types_pkg::light_t      wr_light;
    scene_types_pkg::light_t      base;       // Record before the field replace
    scene_types_pkg::light_t      merged;
    scene_types_pkg::light_t      rmw_q [2];  // Read-modify port data per bank
    scene_types_pkg::light_t      disp_q [2]; // Display port data per bank

    assign light_set = bus.valid && (bus.cmd.opcode == scene_cmd_pkg::OP_LIGHT_SET);

    always_ff @(posedge clk_100mhz) begin
        rd_valid <= light_set;
        mg_valid <= rd_valid;
        wr_valid <= mg_valid;
    end

    always_ff @(posedge clk_100mhz) begin
        rd_cmd   <= bus.cmd;
        mg_cmd   <= rd_cmd;
        wr_index <= mg_cmd.light_index;
        wr_light <= merged;
    end

    // The RAM word was read on the same edge the previous set wrote it,
    // so a match on the write stage means the RAM data is stale
    assign base = (wr_valid && (wr_index == mg_cmd.light_index)) ? wr_light
                                                                : rmw_q[bus.write_bank];

    always_comb begin
        merged = base;
        case (scene_cmd_pkg::light_prop_t'(mg_cmd.prop))
            scene_cmd_pkg::LP_KIND:
                merged.kind = scene_types_pkg::light_kind_t'(mg_cmd.data[1:0]);
            scene_cmd_pkg::LP_X_LOC:     merged.xloc      = mg_cmd.data;
            scene_cmd_pkg::LP_Y_LOC:     merged.yloc      = mg_cmd.data;
            scene_cmd_pkg::LP_Z_LOC:     merged.zloc      = mg_cmd.data;
            scene_cmd_pkg::LP_COLOR:     merged.color     = mg_cmd.data;
            scene_cmd_pkg::LP_INTENSITY: merged.intensity = mg_cmd.data;
            default: ;                   // Codes 6 and 7 change nothing
        endcase
    end

    // One RAM per bank, read-first on both read ports
    for (genvar b = 0; b < 2; b++) begin : g_bank
        scene_types_pkg::light_t ram [num_lights];
        scene_types_pkg::light_t rmw_rd;
        scene_types_pkg::light_t disp_rd;

        always_ff @(posedge clk_100mhz) begin
            if (mg_valid && (bus.write_bank == 1'(b))) begin
                ram[mg_cmd.light_index] <= merged;  // Write bank only
            end
            rmw_rd  <= ram[rd_cmd.light_index];
            disp_rd <= ram[light_read_addr];
        end

        assign rmw_q[b]  = rmw_rd;
        assign disp_q[b] = disp_rd;
    end

    assign light_output   = disp_q[~bus.write_bank];
    assign bus.light_idle = !rd_valid && !mg_valid;  // Nothing left to write

endmodule

`default_nettype wire

//--- design/scene_cmd_if.sv
`default_nettype none
`timescale 1ns/1ps

// Popped command from the intake FIFO, fanned out to both stores
interface scene_cmd_if;

    logic                      valid;        // Command popped this cycle
    scene_cmd_pkg::scene_cmd_t cmd;          // FIFO head, nop while empty
    logic                      write_bank;   // Bank taking updates, display is the other
    logic                      camera_idle;  // No camera update in flight
    logic                      light_idle;   // Light pipeline drained

    // Intake side
    modport issue (output valid, cmd);

    // Sequencer looks at the head before it pops
    modport seq (input valid, cmd, camera_idle, light_idle, output write_bank);

    // Each store drives only its own idle flag
    modport store (input valid, cmd, write_bank, output camera_idle, light_idle);

endinterface

`default_nettype wire

//--- design/scene_cmd_pkg.sv
`default_nettype none

package scene_cmd_pkg;

    typedef enum logic [2:0] {
        OP_NOP        = 3'd0,
        OP_CAMERA_SET = 3'd1,  // One camera field
        OP_LIGHT_SET  = 3'd2,  // One field of one light
        OP_FRAME      = 3'd3,  // Swap banks, enable output
        OP_RENDER     = 3'd4   // Disable output
    } opcode_t;

    // Camera fields, same order as camera_t
    typedef enum logic [2:0] {
        CP_X_LOC, CP_Y_LOC, CP_Z_LOC, CP_X_FOR, CP_Y_FOR, CP_Z_FOR, CP_FOV
    } camera_prop_t;

    // Light fields, same order as light_t
    typedef enum logic [2:0] {
        LP_KIND, LP_X_LOC, LP_Y_LOC, LP_Z_LOC, LP_COLOR, LP_INTENSITY
    } light_prop_t;

    // Host command word, 25 bits
    typedef struct packed {
        opcode_t                       opcode;
        scene_types_pkg::light_addr_t  light_index;  // Light sets only
        logic [2:0]                    prop;         // camera_prop_t or light_prop_t
        scene_types_pkg::field_t       data;         // Low 2 bits carry a light kind
    } scene_cmd_t;

    localparam int CMD_FIFO_DEPTH = 4;  // Also the host's starting credit count

endpackage

`default_nettype wire

//--- design/scene_top.sv
`default_nettype none
`timescale 1ns/1ps

module scene_top #(
    parameter int num_lights = scene_types_pkg::NUM_LIGHTS,
    parameter int fifo_depth = scene_cmd_pkg::CMD_FIFO_DEPTH
) (
    input  wire                               clk_100mhz,
    input  wire                               rst,
    input  wire                               cmd_valid,       // Host command, credit spent
    input  wire scene_cmd_pkg::scene_cmd_t    cmd_word,
    output logic                              cmd_credit,      // Credit returned
    input  wire                               controller_busy,
    input  wire scene_types_pkg::light_addr_t light_read_addr,
    output logic                              output_enabled,
    output scene_types_pkg::camera_t          camera_output,   // Display bank camera
    output scene_types_pkg::light_t           light_output     // Display bank light
);

    logic hold;  // Sequencer back to intake

    scene_cmd_if cmd_bus ();

    cmd_intake #(
        .fifo_depth (fifo_depth)
    ) i_cmd_intake (
        .clk_100mhz (clk_100mhz),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_word   (cmd_word),
        .cmd_credit (cmd_credit),
        .hold       (hold),
        .bus        (cmd_bus.issue)
    );

    // Both stores see every popped command and pick out their own
    camera_store i_camera_store (
        .clk_100mhz    (clk_100mhz),
        .rst           (rst),
        .bus           (cmd_bus.store),
        .camera_output (camera_output)
    );

    light_store #(
        .num_lights (num_lights)
    ) i_light_store (
        .clk_100mhz      (clk_100mhz),
        .bus             (cmd_bus.store),
        .light_read_addr (light_read_addr),
        .light_output    (light_output)
    );

    frame_sequencer i_frame_sequencer (
        .clk_100mhz      (clk_100mhz),
        .rst             (rst),
        .bus             (cmd_bus.seq),
        .controller_busy (controller_busy),
        .hold            (hold),
        .output_enabled  (output_enabled)
    );

endmodule

`default_nettype wire

//--- design/scene_types_pkg.sv
`default_nettype none

package scene_types_pkg;

    // One scene value as sent by the host
    typedef logic [15:0] field_t;

    // Camera record, member order follows the camera property codes
    typedef struct packed {
        field_t xloc;       // Location
        field_t yloc;
        field_t zloc;
        field_t xfor;       // Forward vector
        field_t yfor;
        field_t zfor;
        field_t fov;        // Field of view
    } camera_t;             // 112 bits

    typedef enum logic [1:0] {
        LIGHT_POINT       = 2'd0,
        LIGHT_DIRECTIONAL = 2'd1,
        LIGHT_SPOT        = 2'd2
    } light_kind_t;

    // Light record, 82 bits
    typedef struct packed {
        light_kind_t kind;
        field_t      xloc;
        field_t      yloc;
        field_t      zloc;
        field_t      color;
        field_t      intensity;
    } light_t;

    localparam int NUM_LIGHTS = 8;     // Default light count
    typedef logic [2:0] light_addr_t;  // Light index

endpackage

`default_nettype wire

//--- test/clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module clock_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 8
) (
    output logic clk_100mhz,
    output logic rst
);

    initial begin
        clk_100mhz = 1'b0;
        forever #(period_ns / 2) clk_100mhz = ~clk_100mhz;
    end

    // Held for the reset cycles, released just after an edge like other inputs
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk_100mhz);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- test/scene_asserts.sv
`default_nettype none
`timescale 1ns/1ps

module scene_asserts #(
    parameter int fifo_depth   = scene_cmd_pkg::CMD_FIFO_DEPTH,
    parameter int count_w      = 3,
    parameter bit check_credit = 1'b0,  // Set where bound into cmd_intake
    parameter bit check_swap   = 1'b0   // Set where bound into frame_sequencer
) (
    input wire               clk_100mhz,
    input wire               rst,
    input wire [count_w-1:0] fifo_count,
    input wire               write_bank,
    input wire               frame_pop,    // Frame command popped this cycle
    input wire               stores_idle
);

    int fail_count = 0;  // Read by the testbench at the end

    // Host credits keep the FIFO from holding more than its depth
    credit_bound: assert property (@(posedge clk_100mhz) disable iff (rst || !check_credit)
        (fifo_count <= count_w'(fifo_depth)))
    else begin
        fail_count = fail_count + 1;
        $error("FIFO holds more commands than credits allow");
    end

    bank_steady: assert property (@(posedge clk_100mhz) disable iff (rst || !check_swap)
        !frame_pop |=> $stable(write_bank))
    else begin
        fail_count = fail_count + 1;
        $error("Write bank changed without a frame command");
    end

    // No store update may straddle the swap
    idle_at_swap: assert property (@(posedge clk_100mhz) disable iff (rst || !check_swap)
        frame_pop |-> stores_idle)
    else begin
        fail_count = fail_count + 1;
        $error("Bank swap while a store was busy");
    end

endmodule

bind cmd_intake scene_asserts #(
    .fifo_depth   (fifo_depth),
    .count_w      (cnt_w),
    .check_credit (1'b1)
) i_intake_asserts (
    .clk_100mhz  (clk_100mhz),
    .rst         (rst),
    .fifo_count  (count),
    .write_bank  (1'b0),
    .frame_pop   (1'b0),
    .stores_idle (1'b1)
);

bind frame_sequencer scene_asserts #(
    .count_w    (1),
    .check_swap (1'b1)
) i_seq_asserts (
    .clk_100mhz  (clk_100mhz),
    .rst         (rst),
    .fifo_count  (1'b0),
    .write_bank  (bus.write_bank),
    .frame_pop   (bus.valid && head_frame),
    .stores_idle (bus.camera_idle && bus.light_idle)
);

`default_nettype wire

//--- test/scene_tb.sv
`default_nettype none
`timescale 1ns/1ps

module scene_tb;

    localparam int fifo_depth  = scene_cmd_pkg::CMD_FIFO_DEPTH;
    localparam int num_lights  = scene_types_pkg::NUM_LIGHTS;
    localparam int cycle_limit = 2000;  // Tests need under 200 cycles

    logic                         clk_100mhz;
    logic                         rst;
    logic                         cmd_valid;
    scene_cmd_pkg::scene_cmd_t    cmd_word;
    logic                         cmd_credit;
    logic                         controller_busy;
    scene_types_pkg::light_addr_t light_read_addr;
    logic                         output_enabled;
    scene_types_pkg::camera_t     camera_output;
    scene_types_pkg::light_t      light_output;

    int unsigned error_count;
    int unsigned assert_failures;
    int unsigned cycle_count;
    int unsigned credits_sent;              // Credits spent by the host
    int unsigned credits_back;              // Pulses seen on cmd_credit
    logic [31:0] lcg_state;

    // Reference model of both banks
    logic [15:0] cam_model [2][7];
    logic [15:0] light_model [2][num_lights][6];  // Entry 0 is the kind, low 2 bits
    logic        model_bank;                      // Write bank, display is the other

    clock_gen #(.period_ns(10), .reset_cycles(8)) i_clock_gen (
        .clk_100mhz (clk_100mhz),
        .rst        (rst)
    );

    scene_top #(
        .num_lights (num_lights),
        .fifo_depth (fifo_depth)
    ) i_dut (
        .clk_100mhz      (clk_100mhz),
        .rst             (rst),
        .cmd_valid       (cmd_valid),
        .cmd_word        (cmd_word),
        .cmd_credit      (cmd_credit),
        .controller_busy (controller_busy),
        .light_read_addr (light_read_addr),
        .output_enabled  (output_enabled),
        .camera_output   (camera_output),
        .light_output    (light_output)
    );

    // Credit return counter and hang guard
    always @(posedge clk_100mhz) begin
        cycle_count <= cycle_count + 1;
        if (!rst && cmd_credit) begin
            credits_back <= credits_back + 1;
        end
        if (cycle_count == cycle_limit) begin
            $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];  // Upper bits have the longer period
    endfunction

    // Record layouts as the command field order defines them
    function automatic logic [111:0] expected_camera(input logic bank);
        return {cam_model[bank][0], cam_model[bank][1], cam_model[bank][2],
                cam_model[bank][3], cam_model[bank][4], cam_model[bank][5],
                cam_model[bank][6]};
    endfunction

    function automatic logic [81:0] expected_light(input logic bank, input logic [2:0] index);
        return {light_model[bank][index][0][1:0], light_model[bank][index][1],
                light_model[bank][index][2], light_model[bank][index][3],
                light_model[bank][index][4], light_model[bank][index][5]};
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic step();
        @(posedge clk_100mhz);
        #1;  // Inputs change just after the edge
    endtask

    // Spends a credit, waits while none is left; model follows in command order
    task automatic send_cmd(input scene_cmd_pkg::opcode_t op, input logic [2:0] index,
                            input logic [2:0] prop, input logic [15:0] data);
        while (credits_sent - credits_back >= fifo_depth) begin
            step();
        end
        cmd_word.opcode      = op;
        cmd_word.light_index = index;
        cmd_word.prop        = prop;
        cmd_word.data        = data;
        cmd_valid            = 1'b1;
        credits_sent++;
        step();
        cmd_valid = 1'b0;
        case (op)
            scene_cmd_pkg::OP_CAMERA_SET: cam_model[model_bank][prop] = data;
            scene_cmd_pkg::OP_LIGHT_SET:  light_model[model_bank][index][prop] = data;
            scene_cmd_pkg::OP_FRAME:      model_bank = ~model_bank;
            default: ;
        endcase
    endtask

    // All credits back, then room for the light write, the swap and a display read
    task automatic wait_drain();
        while (credits_back < credits_sent) begin
            step();
        end
        repeat (3) step();
        check_value("credits returned", credits_sent, credits_back);  // One per command
    endtask

    task automatic check_outputs(input logic [111:0] cam, input logic enable);
        @(negedge clk_100mhz);
        check_value("camera_output", cam, camera_output);
        check_value("output_enabled", enable, output_enabled);
        step();
    endtask

    task automatic check_light(input logic [2:0] index);
        light_read_addr = index;
        step();              // Display port is one cycle behind the address
        @(negedge clk_100mhz);
        check_value("light_output", expected_light(~model_bank, index), light_output);
        step();
    endtask

    task automatic test_reset();
        @(negedge clk_100mhz);
        check_value("cmd_credit", 1'b0, cmd_credit);
        step();
        check_outputs('0, 1'b0);
    endtask

    task automatic test_camera_rmw();
        send_cmd(scene_cmd_pkg::OP_CAMERA_SET, 3'd0, scene_cmd_pkg::CP_X_LOC, next_random());
        send_cmd(scene_cmd_pkg::OP_CAMERA_SET, 3'd0, scene_cmd_pkg::CP_FOV, next_random());
        send_cmd(scene_cmd_pkg::OP_FRAME, 3'd0, 3'd0, 16'h0);
        wait_drain();
        check_outputs(expected_camera(~model_bank), 1'b1);  // Other five fields stay zero
    endtask

    task automatic test_light_forwarding();
        logic [15:0] kind_data;
        int          p;
        kind_data      = next_random();
        kind_data[1:0] = 2'd2;  // Spot, upper bits are don't care
        send_cmd(scene_cmd_pkg::OP_LIGHT_SET, 3'd5, scene_cmd_pkg::LP_KIND, kind_data);
        for (p = 1; p < 6; p++) begin
            send_cmd(scene_cmd_pkg::OP_LIGHT_SET, 3'd5, 3'(p), next_random());
        end
        send_cmd(scene_cmd_pkg::OP_LIGHT_SET, 3'd5, scene_cmd_pkg::LP_COLOR, next_random());
        send_cmd(scene_cmd_pkg::OP_FRAME, 3'd0, 3'd0, 16'h0);
        wait_drain();
        check_light(3'd5);
        check_outputs(expected_camera(~model_bank), 1'b1);  // Camera bank never written
    endtask

    task automatic test_double_buffer();
        send_cmd(scene_cmd_pkg::OP_CAMERA_SET, 3'd0, scene_cmd_pkg::CP_Y_LOC, next_random());
        wait_drain();
        check_outputs(expected_camera(~model_bank), 1'b1);  // Not visible before a frame
        send_cmd(scene_cmd_pkg::OP_FRAME, 3'd0, 3'd0, 16'h0);
        wait_drain();
        check_outputs(expected_camera(~model_bank), 1'b1);
        send_cmd(scene_cmd_pkg::OP_CAMERA_SET, 3'd0, scene_cmd_pkg::CP_X_FOR, next_random());
        send_cmd(scene_cmd_pkg::OP_FRAME, 3'd0, 3'd0, 16'h0);
        wait_drain();
        check_outputs(expected_camera(~model_bank), 1'b1);  // No copy, y location gone
        check_light(3'd5);
    endtask

    task automatic test_frame_hold();
        logic [111:0] held;
        int unsigned  back_before;
        held            = expected_camera(~model_bank);
        back_before     = credits_back;
        controller_busy = 1'b1;
        send_cmd(scene_cmd_pkg::OP_FRAME, 3'd0, 3'd0, 16'h0);
        send_cmd(scene_cmd_pkg::OP_CAMERA_SET, 3'd0, scene_cmd_pkg::CP_Z_LOC, next_random());
        repeat (20) step();   // Window in which nothing may move
        check_value("credits while busy", back_before, credits_back);
        check_outputs(held, 1'b1);
        controller_busy = 1'b0;
        wait_drain();
        check_outputs(expected_camera(~model_bank), 1'b1);
        send_cmd(scene_cmd_pkg::OP_RENDER, 3'd0, 3'd0, 16'h0);
        wait_drain();
        check_outputs(expected_camera(~model_bank), 1'b0);
    endtask

    initial begin
        cmd_valid       = 1'b0;
        cmd_word        = '0;
        controller_busy = 1'b0;
        light_read_addr = '0;
        error_count     = 0;
        cycle_count     = 0;
        credits_sent    = 0;
        credits_back    = 0;
        lcg_state       = 32'h3a87_9f28;
        model_bank      = 1'b0;
        cam_model       = '{default: '0};
        light_model     = '{default: '0};
        @(negedge rst);
        test_reset();
        test_camera_rmw();
        test_light_forwarding();
        test_double_buffer();
        test_frame_hold();
        assert_failures = i_dut.i_cmd_intake.i_intake_asserts.fail_count
                        + i_dut.i_frame_sequencer.i_seq_asserts.fail_count;
        $display("Errors: %0d compare, %0d assertion", error_count, assert_failures);
        if (error_count == 0 && assert_failures == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
